// File: logic/jtagDebugPkg.sv
// Opcodes, data and storage widths, IDCODE constant and shared types of the debug target
`default_nettype none

package jtagDebugPkg;

  // ----------------------------------------
  // Instruction register
  // ----------------------------------------
  // Opcodes 5 and 13 are unused by this target
  typedef enum logic [3:0] {
    BYPASS_OP      = 4'd0,
    IDCODE_OP      = 4'd1,
    READREG_OP     = 4'd2,
    SETREGISTER_OP = 4'd3,
    RUNTEST_OP     = 4'd4,
    SETTEST_OP     = 4'd6,
    WRITEREG_OP    = 4'd7,
    READTXT_OP     = 4'd8,
    SETTXTIDX_OP   = 4'd9,
    WRITETXT_OP    = 4'd10,
    RESETHI_OP     = 4'd11,
    RESETLO_OP     = 4'd12,
    SELTEST_OP     = 4'd14,
    BYPASS_ALT_OP  = 4'd15
  } opcode_t;

  // ----------------------------------------
  // Data register and storage
  // ----------------------------------------
  localparam int DR_WIDTH = 32;
  typedef logic [DR_WIDTH-1:0] drWord_t;
  typedef logic [7:0] textByte_t;

  // Register file and text buffer depths
  localparam int REG_COUNT = 8;
  localparam int TEXT_DEPTH = 32;
  typedef logic [$clog2(REG_COUNT)-1:0] regAddr_t;
  typedef logic [$clog2(TEXT_DEPTH)-1:0] textAddr_t;

  // Test number and wrapping command counter
  typedef logic [3:0] testId_t;
  typedef logic [7:0] cmdCount_t;

  // Device identification word
  localparam drWord_t IDCODE_VALUE = 32'h100011D3;

endpackage

`default_nettype wire

// File: logic/debugIfs.sv
// Interfaces storePort (memory access) and shiftRegs (shifter registers) with modports
`default_nettype none
`timescale 1ns/1ps

// One access port of a shared storage block
interface storePort #(
  parameter type payload_t = logic [7:0],
  parameter int ADDR_W = 3
);
  logic req;
  logic we;
  logic [ADDR_W-1:0] addr;
  payload_t wdata;
  // Read data, valid in the granted cycle
  payload_t rdata;
  logic gnt;

  modport client (output req, output we, output addr, output wdata, input rdata, input gnt);
  modport store (input req, input we, input addr, input wdata, output rdata, output gnt);
endinterface

// Registers owned by the data shifter, read by the executor
interface shiftRegs;
  import jtagDebugPkg::*;

  drWord_t shiftData;
  regAddr_t regIndex;
  textAddr_t textIndex;
  testId_t testSelect;

  modport source (output shiftData, output regIndex, output textIndex, output testSelect);
  modport sink (input shiftData, input regIndex, input textIndex, input testSelect);
endinterface

`default_nettype wire

// File: logic/sharedStore.sv
// Typed flop-array memory shared by a writer and a reader through a fixed-priority arbiter
`default_nettype none
`timescale 1ns/1ps

module sharedStore #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 8
) (
  input logic clk,
  input logic reset,
  storePort.store writer,
  storePort.store reader
);
  localparam int ADDR_W = $clog2(DEPTH);

  payload_t mem [DEPTH];
  // Entries written since reset, unwritten ones read as zero
  logic [DEPTH-1:0] written;
  logic [ADDR_W-1:0] accessAddr;
  payload_t accessData;

  // ----------------------------------------
  // Arbiter
  // ----------------------------------------
  // Writer side always wins, reader waits
  assign writer.gnt = writer.req;
  assign reader.gnt = reader.req && !writer.req;

  // Single access path into the array
  assign accessAddr = writer.req ? writer.addr : reader.addr;
  assign accessData = written[accessAddr] ? mem[accessAddr] : '0;

  // Same-cycle read data to both sides
  assign writer.rdata = accessData;
  assign reader.rdata = accessData;

  // ----------------------------------------
  // Array
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (writer.gnt && writer.we)
      mem[writer.addr] <= writer.wdata;
    else if (reader.gnt && reader.we)
      mem[reader.addr] <= reader.wdata;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      written <= '0;
    else if (writer.gnt && writer.we)
      written[writer.addr] <= 1'b1;
    else if (reader.gnt && reader.we)
      written[reader.addr] <= 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/instructionTracker.sv
// Instruction-register watcher with opcode latch, request counter and soft-reset control
`default_nettype none
`timescale 1ns/1ps

module instructionTracker (
  input logic clk,
  input logic reset,
  input jtagDebugPkg::opcode_t irIn,
  input logic uir,
  output jtagDebugPkg::opcode_t opcode,
  output jtagDebugPkg::cmdCount_t cmdRequested,
  output logic targetReleased
);
  import jtagDebugPkg::*;

  typedef enum logic [1:0] {
    idle,
    newInstruction,
    settle
  } trackState_t;

  trackState_t state;
  // Copy of the instruction seen at detection
  opcode_t irCopy;
  logic isResetOp;
  logic isCounted;

  // Soft-reset opcodes clear the count instead of bumping it
  assign isResetOp = (irCopy == RESETLO_OP) || (irCopy == RESETHI_OP);
  // Bypass codes follow every instruction and are not commands
  assign isCounted = (irCopy != BYPASS_OP) && (irCopy != BYPASS_ALT_OP) && !isResetOp;

  always_ff @(posedge clk)
  begin
    if (state == idle && uir && irIn != opcode)
      irCopy <= irIn;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= idle;
      opcode <= BYPASS_OP;
      cmdRequested <= '0;
      targetReleased <= 1'b1;
    end
    else
    begin
      case (state)
        // Wait for a changed instruction with uir high
        idle:
        begin
          if (uir && irIn != opcode)
            state <= newInstruction;
        end
        // Latch it and update the request count
        newInstruction:
        begin
          opcode <= irCopy;
          if (isResetOp)
            cmdRequested <= '0;
          else if (isCounted)
            cmdRequested <= cmdRequested + 1'b1;
          state <= settle;
        end
        // Soft-reset level follows one cycle later
        settle:
        begin
          if (opcode == RESETLO_OP)
            targetReleased <= 1'b0;
          else if (opcode == RESETHI_OP)
            targetReleased <= 1'b1;
          state <= idle;
        end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/dataShifter.sv
// Data shift register with capture reads, update-DR index registers and tdo output mux
`default_nettype none
`timescale 1ns/1ps

module dataShifter (
  input logic clk,
  input logic reset,
  input jtagDebugPkg::opcode_t opcode,
  input jtagDebugPkg::opcode_t irIn,
  input logic cdr,
  input logic sdr,
  input logic udr,
  input logic tdi,
  output logic tdo,
  storePort.client regRead,
  storePort.client textRead,
  shiftRegs.source regs
);
  import jtagDebugPkg::*;

  // Capture reads waiting for a grant
  logic regPending;
  logic textPending;
  logic regLoad;
  logic textLoad;

  // ----------------------------------------
  // Capture read ports
  // ----------------------------------------
  // Read only, address straight from the index registers
  assign regRead.req = regPending;
  assign regRead.we = 1'b0;
  assign regRead.addr = regs.regIndex;
  assign regRead.wdata = '0;

  assign textRead.req = textPending;
  assign textRead.we = 1'b0;
  assign textRead.addr = regs.textIndex;
  assign textRead.wdata = '0;

  assign regLoad = regPending && regRead.gnt;
  assign textLoad = textPending && textRead.gnt;

  // Request held until the arbiter grants it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regPending <= 1'b0;
      textPending <= 1'b0;
    end
    else
    begin
      if (cdr && opcode == READREG_OP)
        regPending <= 1'b1;
      else if (regLoad)
        regPending <= 1'b0;
      if (cdr && opcode == READTXT_OP)
        textPending <= 1'b1;
      else if (textLoad)
        textPending <= 1'b0;
    end
  end

  // ----------------------------------------
  // Shift register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      regs.shiftData <= '0;
    else if (regLoad)
      regs.shiftData <= regRead.rdata;
    else if (textLoad)
      // Text byte zero-extended to a full word
      regs.shiftData <= drWord_t'(textRead.rdata);
    else if (cdr && opcode == IDCODE_OP)
      regs.shiftData <= IDCODE_VALUE;
    else if (sdr)
      // New bit enters at the top, LSB leaves first
      regs.shiftData <= {tdi, regs.shiftData[DR_WIDTH-1:1]};
  end

  // Update-DR loads the index registers from the low bits
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regs.regIndex <= '0;
      regs.textIndex <= '0;
      regs.testSelect <= '0;
    end
    else if (udr)
    begin
      case (opcode)
        SETREGISTER_OP: regs.regIndex <= regs.shiftData[$bits(regAddr_t)-1:0];
        SETTXTIDX_OP: regs.textIndex <= regs.shiftData[$bits(textAddr_t)-1:0];
        SETTEST_OP: regs.testSelect <= regs.shiftData[$bits(testId_t)-1:0];
        default: ;
      endcase
    end
  end

  // Alternate bypass code loops tdi straight to tdo
  assign tdo = (irIn == BYPASS_ALT_OP) ? tdi : regs.shiftData[0];

endmodule

`default_nettype wire

// File: logic/commandExecutor.sv
// Command FSM with storage writes, test select and run, and run-button debounce
`default_nettype none
`timescale 1ns/1ps

module commandExecutor #(
  parameter int DEBOUNCE_CYCLES = 1250000
) (
  input logic clk,
  input logic reset,
  input logic targetReleased,
  input jtagDebugPkg::opcode_t opcode,
  input jtagDebugPkg::cmdCount_t cmdRequested,
  input logic runButtonN,
  shiftRegs.sink regs,
  storePort.client regWrite,
  storePort.client textWrite,
  output jtagDebugPkg::cmdCount_t cmdDone,
  output logic testRun,
  output jtagDebugPkg::testId_t selectedTest,
  output jtagDebugPkg::testId_t lastSelectedTest,
  output logic debounceActive
);
  import jtagDebugPkg::*;

  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  typedef enum logic [2:0] {
    trigReset,
    trigCheckManual,
    trigManualRun,
    trigManualDebounce,
    trigCheckCommand,
    trigExecute,
    trigResetRun
  } trigState_t;

  trigState_t state;
  logic [CNT_W-1:0] debounceCount;
  // Two-flop synchronizer for the button
  logic [1:0] buttonSync;
  logic buttonPressed;
  logic executing;

  assign buttonPressed = !buttonSync[1];
  assign executing = (state == trigExecute);

  always_ff @(posedge clk)
  begin
    if (reset)
      buttonSync <= 2'b11;
    else
      buttonSync <= {buttonSync[0], runButtonN};
  end

  // ----------------------------------------
  // Storage writes
  // ----------------------------------------
  // One-cycle writes, always granted
  assign regWrite.req = executing && (opcode == WRITEREG_OP);
  assign regWrite.we = 1'b1;
  assign regWrite.addr = regs.regIndex;
  assign regWrite.wdata = regs.shiftData;

  assign textWrite.req = executing && (opcode == WRITETXT_OP);
  assign textWrite.we = 1'b1;
  assign textWrite.addr = regs.textIndex;
  assign textWrite.wdata = regs.shiftData[$bits(textByte_t)-1:0];

  // ----------------------------------------
  // Trigger FSM
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= trigReset;
      cmdDone <= '0;
      testRun <= 1'b0;
      selectedTest <= '0;
      lastSelectedTest <= '0;
      debounceActive <= 1'b0;
      debounceCount <= '0;
    end
    else if (!targetReleased)
    begin
      // Held by soft reset
      state <= trigReset;
      cmdDone <= '0;
      lastSelectedTest <= '0;
      testRun <= 1'b0;
    end
    else
    begin
      // testRun is a single-cycle pulse
      testRun <= 1'b0;
      case (state)
        trigReset:
        begin
          cmdDone <= '0;
          debounceActive <= 1'b0;
          debounceCount <= '0;
          state <= trigCheckManual;
        end
        trigCheckManual:
        begin
          // Button ignored while debounce runs
          if (debounceActive)
            state <= trigManualDebounce;
          else if (buttonPressed)
            state <= trigManualRun;
          else
            state <= trigCheckCommand;
        end
        trigManualRun:
        begin
          debounceActive <= 1'b1;
          testRun <= 1'b1;
          state <= trigCheckCommand;
        end
        trigManualDebounce:
        begin
          // Counts once per visit
          if (debounceCount == CNT_W'(DEBOUNCE_CYCLES - 1))
          begin
            debounceActive <= 1'b0;
            debounceCount <= '0;
          end
          else
            debounceCount <= debounceCount + 1'b1;
          state <= trigCheckCommand;
        end
        trigCheckCommand:
        begin
          if (cmdRequested != cmdDone)
            state <= trigExecute;
          else
            state <= trigCheckManual;
        end
        trigExecute:
        begin
          cmdDone <= cmdRequested;
          // Memory writes happen through the ports this cycle
          if (opcode == SELTEST_OP || opcode == RUNTEST_OP)
          begin
            selectedTest <= regs.testSelect;
            lastSelectedTest <= regs.testSelect;
          end
          if (opcode == RUNTEST_OP)
          begin
            testRun <= 1'b1;
            state <= trigResetRun;
          end
          else
            state <= trigCheckManual;
        end
        trigResetRun:
        begin
          // Run launched, selection drops back
          selectedTest <= '0;
          state <= trigCheckManual;
        end
        default:
          state <= trigReset;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/jtagDebugTop.sv
// Debug target top level with plain ports, interface instances and submodule wiring
`default_nettype none
`timescale 1ns/1ps

module jtagDebugTop #(
  parameter int DEBOUNCE_CYCLES = 1250000
) (
  input logic clk,
  input logic reset,
  input jtagDebugPkg::opcode_t irIn,
  input logic uir,
  input logic cdr,
  input logic sdr,
  input logic udr,
  input logic tdi,
  output logic tdo,
  input logic runButtonN,
  output logic testRun,
  output jtagDebugPkg::testId_t selectedTest,
  output jtagDebugPkg::testId_t lastSelectedTest,
  output jtagDebugPkg::cmdCount_t cmdRequested,
  output jtagDebugPkg::cmdCount_t cmdDone,
  output logic debounceActive,
  output logic targetReleased
);
  import jtagDebugPkg::*;

  // Latched instruction shared by shifter and executor
  opcode_t opcode;

  // ----------------------------------------
  // Interface instances
  // ----------------------------------------
  storePort #(.payload_t(drWord_t), .ADDR_W($bits(regAddr_t))) regWritePort ();
  storePort #(.payload_t(drWord_t), .ADDR_W($bits(regAddr_t))) regReadPort ();
  storePort #(.payload_t(textByte_t), .ADDR_W($bits(textAddr_t))) textWritePort ();
  storePort #(.payload_t(textByte_t), .ADDR_W($bits(textAddr_t))) textReadPort ();
  shiftRegs regsBus ();

  instructionTracker tracker_i (
    .clk(clk),
    .reset(reset),
    .irIn(irIn),
    .uir(uir),
    .opcode(opcode),
    .cmdRequested(cmdRequested),
    .targetReleased(targetReleased)
  );

  dataShifter shifter_i (
    .clk(clk),
    .reset(reset),
    .opcode(opcode),
    .irIn(irIn),
    .cdr(cdr),
    .sdr(sdr),
    .udr(udr),
    .tdi(tdi),
    .tdo(tdo),
    .regRead(regReadPort.client),
    .textRead(textReadPort.client),
    .regs(regsBus.source)
  );

  commandExecutor #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) executor_i (
    .clk(clk),
    .reset(reset),
    .targetReleased(targetReleased),
    .opcode(opcode),
    .cmdRequested(cmdRequested),
    .runButtonN(runButtonN),
    .regs(regsBus.sink),
    .regWrite(regWritePort.client),
    .textWrite(textWritePort.client),
    .cmdDone(cmdDone),
    .testRun(testRun),
    .selectedTest(selectedTest),
    .lastSelectedTest(lastSelectedTest),
    .debounceActive(debounceActive)
  );

  // Register file, executor writes and capture reads
  sharedStore #(.payload_t(drWord_t), .DEPTH(REG_COUNT)) regFile_i (
    .clk(clk),
    .reset(reset),
    .writer(regWritePort.store),
    .reader(regReadPort.store)
  );

  // Text buffer, one byte per entry
  sharedStore #(.payload_t(textByte_t), .DEPTH(TEXT_DEPTH)) textBuf_i (
    .clk(clk),
    .reset(reset),
    .writer(textWritePort.store),
    .reader(textReadPort.store)
  );

endmodule

`default_nettype wire

// File: verif/jtagDebug_props.sv
// Concurrent checks on the run pulse, the storage arbiter grants and the command counters
`default_nettype none
`timescale 1ns/1ps

module jtagDebugProps (
  input logic clk,
  input logic reset,
  input logic testRun,
  input logic readerReq,
  input logic readerGnt,
  input jtagDebugPkg::cmdCount_t cmdRequested,
  input jtagDebugPkg::cmdCount_t cmdDone
);

  // Sticky, set by any failing check below
  logic failed = 1'b0;

  // ----------------------------------------
  // Executor
  // ----------------------------------------
  // Run request is a single-cycle pulse
  runPulseOneCycle: assert property (@(posedge clk) disable iff (reset)
    testRun |=> !testRun)
    else
    begin
      failed = 1'b1;
      $error("testRun stayed high for more than one cycle");
    end

  // cmdDone only catches up to the requested count, or clears on soft reset
  doneFollowsRequest: assert property (@(posedge clk) disable iff (reset)
    (cmdDone != $past(cmdDone)) |-> (cmdDone == $past(cmdRequested) || cmdDone == '0))
    else
    begin
      failed = 1'b1;
      $error("cmdDone moved past cmdRequested");
    end

  // ----------------------------------------
  // Storage arbiter
  // ----------------------------------------
  // A refused capture read is held and granted in the next cycle
  readStallOneCycle: assert property (@(posedge clk) disable iff (reset)
    (readerReq && !readerGnt) |=> (readerReq && readerGnt))
    else
    begin
      failed = 1'b1;
      $error("capture read waited more than one cycle for its grant");
    end

endmodule

// Executor side, storage ports unused here
bind commandExecutor jtagDebugProps executorProps_i (
  .clk(clk),
  .reset(reset),
  .testRun(testRun),
  .readerReq(1'b0),
  .readerGnt(1'b0),
  .cmdRequested(cmdRequested),
  .cmdDone(cmdDone)
);

// Both storage blocks, counters unused here
bind sharedStore jtagDebugProps storeProps_i (
  .clk(clk),
  .reset(reset),
  .testRun(1'b0),
  .readerReq(reader.req),
  .readerGnt(reader.gnt),
  .cmdRequested(8'h00),
  .cmdDone(8'h00)
);

`default_nettype wire

// File: verif/jtagDebugTb.sv
// Debug target testbench with clock, reset, JTAG host tasks, stimulus table and checks
`default_nettype none
`timescale 1ns/1ps

module jtagDebugTb;
  import jtagDebugPkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // Signals that the wait loop can poll
  typedef enum int {
    selRequested,
    selDone,
    selReleased,
    selPulses,
    selDebounce
  } waitSel_t;

  logic clk;
  logic reset;
  opcode_t irIn;
  logic uir;
  logic cdr;
  logic sdr;
  logic udr;
  logic tdi;
  logic tdo;
  logic runButtonN;
  logic testRun;
  testId_t selectedTest;
  testId_t lastSelectedTest;
  cmdCount_t cmdRequested;
  cmdCount_t cmdDone;
  logic debounceActive;
  logic targetReleased;

  logic [31:0] lfsrState;
  int runPulses = 0;
  testId_t setTest;

  // Stimulus table, one row per scan
  opcode_t rowOp [$];
  drWord_t rowIn [$];
  drWord_t rowExp [$];

  // Reference state used to fill the expected column
  drWord_t modelReg [REG_COUNT];
  textByte_t modelText [TEXT_DEPTH];
  regAddr_t modelRegIdx;
  textAddr_t modelTextIdx;
  drWord_t lastShift;

  jtagDebugTop #(.DEBOUNCE_CYCLES(20)) dut_i (
    .clk(clk),
    .reset(reset),
    .irIn(irIn),
    .uir(uir),
    .cdr(cdr),
    .sdr(sdr),
    .udr(udr),
    .tdi(tdi),
    .tdo(tdo),
    .runButtonN(runButtonN),
    .testRun(testRun),
    .selectedTest(selectedTest),
    .lastSelectedTest(lastSelectedTest),
    .cmdRequested(cmdRequested),
    .cmdDone(cmdDone),
    .debounceActive(debounceActive),
    .targetReleased(targetReleased)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Count run pulses where testRun is stable
  always @(negedge clk)
  begin
    if (testRun)
      runPulses <= runPulses + 1;
  end

  // Bound assertion failures end the run
  always @(negedge clk)
  begin
    assert (!(dut_i.executor_i.executorProps_i.failed ||
              dut_i.regFile_i.storeProps_i.failed ||
              dut_i.textBuf_i.storeProps_i.failed))
    else
      failNow("A concurrent assertion on the DUT failed");
  end

  // ----------------------------------------
  // Checking helpers
  // ----------------------------------------
  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] want);
    assert (got === want)
    else
      failNow($sformatf("Fail %s: got %h, expected %h", name, got, want));
  endtask

  // Polls one signal on the falling edge until it matches
  task automatic waitFor(input waitSel_t sel, input logic [31:0] want, input string what);
    logic [31:0] now;
    for (int cycles = 0; cycles < TIMEOUT_CYCLES; cycles++)
    begin
      @(negedge clk);
      case (sel)
        selRequested: now = cmdRequested;
        selDone: now = cmdDone;
        selReleased: now = targetReleased;
        selPulses: now = runPulses;
        default: now = debounceActive;
      endcase
      if (now == want)
        return;
    end
    failNow($sformatf("Timed out waiting for %s", what));
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsrBits(input int count);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < count; i++)
    begin
      word[i] = lfsrState[0];
      lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? LFSR_TAPS : 32'h0);
    end
    return word;
  endfunction

  // ----------------------------------------
  // JTAG host
  // ----------------------------------------
  // Tracker is idle again three cycles after detection
  task automatic pulseInstruction(input opcode_t op);
    @(negedge clk);
    irIn = op;
    uir = 1'b1;
    @(negedge clk);
    uir = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // Counted opcode, both counters step by one
  task automatic issueCommand(input opcode_t op);
    cmdCount_t want;
    want = cmdRequested + 1'b1;
    pulseInstruction(op);
    waitFor(selRequested, 32'(want), "cmdRequested to count the command");
    waitFor(selDone, 32'(want), "cmdDone to catch up");
    checkValue("cmdRequested", 32'(cmdRequested), 32'(want));
  endtask

  // Capture, 32 shifts LSB first, then update
  task automatic scanData(input drWord_t din, output drWord_t dout);
    @(negedge clk);
    cdr = 1'b1;
    @(negedge clk);
    cdr = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = 0; i < DR_WIDTH; i++)
    begin
      dout[i] = tdo;
      tdi = din[i];
      sdr = 1'b1;
      @(negedge clk);
    end
    sdr = 1'b0;
    udr = 1'b1;
    @(negedge clk);
    udr = 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  // Writes take the word shifted before the command, reads capture, others show it again
  task automatic addRow(input opcode_t op, input drWord_t din);
    drWord_t expected;
    if (op == WRITEREG_OP)
      modelReg[modelRegIdx] = lastShift;
    if (op == WRITETXT_OP)
      modelText[modelTextIdx] = lastShift[7:0];
    case (op)
      IDCODE_OP: expected = 32'h100011D3;
      READREG_OP: expected = modelReg[modelRegIdx];
      READTXT_OP: expected = {24'h0, modelText[modelTextIdx]};
      default: expected = lastShift;
    endcase
    if (op == SETREGISTER_OP)
      modelRegIdx = din[2:0];
    if (op == SETTXTIDX_OP)
      modelTextIdx = din[4:0];
    lastShift = din;
    rowOp.push_back(op);
    rowIn.push_back(din);
    rowExp.push_back(expected);
  endtask

  task automatic buildTable();
    addRow(IDCODE_OP, lfsrBits(32));
    // Fill three registers, then read them back
    for (int k = 0; k < 3; k++)
    begin
      addRow(SETREGISTER_OP, 32'((k * 5 + 1) % REG_COUNT));
      addRow(BYPASS_OP, lfsrBits(32));
      addRow(WRITEREG_OP, lfsrBits(32));
    end
    for (int k = 0; k < 3; k++)
    begin
      addRow(SETREGISTER_OP, 32'((k * 5 + 1) % REG_COUNT));
      addRow(READREG_OP, lfsrBits(32));
    end
    // Same pattern on the text buffer
    for (int k = 0; k < 3; k++)
    begin
      addRow(SETTXTIDX_OP, 32'((k * 13 + 2) % TEXT_DEPTH));
      addRow(BYPASS_OP, lfsrBits(32));
      addRow(WRITETXT_OP, lfsrBits(32));
    end
    for (int k = 0; k < 3; k++)
    begin
      addRow(SETTXTIDX_OP, 32'((k * 13 + 2) % TEXT_DEPTH));
      addRow(READTXT_OP, lfsrBits(32));
    end
    addRow(SETTEST_OP, 32'd11);
    addRow(SELTEST_OP, lfsrBits(32));
    addRow(RUNTEST_OP, lfsrBits(32));
  endtask

  task automatic applyRow(input int i);
    drWord_t captured;
    int pulsesBefore;
    pulsesBefore = runPulses;
    if (rowOp[i] != BYPASS_OP)
      issueCommand(rowOp[i]);
    scanData(rowIn[i], captured);
    checkValue($sformatf("tdo word in row %0d", i), captured, rowExp[i]);
    if (rowOp[i] == SETTEST_OP)
      setTest = rowIn[i][3:0];
    if (rowOp[i] == SELTEST_OP)
      checkValue("selectedTest", 32'(selectedTest), 32'(setTest));
    if (rowOp[i] == RUNTEST_OP)
    begin
      checkValue("testRun pulse count", 32'(runPulses), 32'(pulsesBefore + 1));
      checkValue("lastSelectedTest", 32'(lastSelectedTest), 32'(setTest));
    end
    if (rowOp[i] != BYPASS_OP)
      pulseInstruction(BYPASS_OP);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    int pulsesBefore;
    irIn = BYPASS_OP;
    uir = 1'b0;
    cdr = 1'b0;
    sdr = 1'b0;
    udr = 1'b0;
    tdi = 1'b0;
    runButtonN = 1'b1;
    reset = 1'b1;
    lfsrState = 32'h5672;
    setTest = '0;
    modelRegIdx = '0;
    modelTextIdx = '0;
    lastShift = '0;
    for (int i = 0; i < REG_COUNT; i++)
      modelReg[i] = '0;
    for (int i = 0; i < TEXT_DEPTH; i++)
      modelText[i] = '0;
    buildTable();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checkValue("targetReleased", 32'(targetReleased), 32'd1);
    checkValue("testRun", 32'(testRun), 32'd0);
    checkValue("cmdDone", 32'(cmdDone), 32'd0);
    checkValue("selectedTest", 32'(selectedTest), 32'd0);

    // IDCODE, register and text round trips, test select and run
    for (int i = 0; i < rowOp.size(); i++)
      applyRow(i);

    // Soft reset drops the target, then releases it
    pulseInstruction(RESETLO_OP);
    waitFor(selReleased, 32'd0, "targetReleased to go low");
    waitFor(selDone, 32'd0, "cmdDone to clear");
    checkValue("cmdRequested", 32'(cmdRequested), 32'd0);
    checkValue("lastSelectedTest", 32'(lastSelectedTest), 32'd0);
    pulseInstruction(RESETHI_OP);
    waitFor(selReleased, 32'd1, "targetReleased to go high");
    checkValue("cmdRequested", 32'(cmdRequested), 32'd0);
    pulseInstruction(BYPASS_OP);

    // Button press runs, a second press during debounce is ignored
    pulsesBefore = runPulses;
    @(negedge clk);
    runButtonN = 1'b0;
    waitFor(selPulses, 32'(pulsesBefore + 1), "a testRun pulse from the button");
    checkValue("debounceActive", 32'(debounceActive), 32'd1);
    runButtonN = 1'b1;
    repeat (2) @(negedge clk);
    runButtonN = 1'b0;
    repeat (8) @(negedge clk);
    runButtonN = 1'b1;
    checkValue("debounceActive", 32'(debounceActive), 32'd1);
    checkValue("testRun pulse count", 32'(runPulses), 32'(pulsesBefore + 1));
    waitFor(selDebounce, 32'd0, "debounce to end");
    checkValue("testRun pulse count", 32'(runPulses), 32'(pulsesBefore + 1));

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/jtagDebugPkg.sv
logic/debugIfs.sv
logic/sharedStore.sv
logic/instructionTracker.sv
logic/dataShifter.sv
logic/commandExecutor.sv
logic/jtagDebugTop.sv
verif/jtagDebug_props.sv
verif/jtagDebugTb.sv

// File: Bender.yml
package:
  name: jtag_debug

sources:
  - logic/jtagDebugPkg.sv
  - logic/debugIfs.sv
  - logic/sharedStore.sv
  - logic/instructionTracker.sv
  - logic/dataShifter.sv
  - logic/commandExecutor.sv
  - logic/jtagDebugTop.sv
  - target: test
    files:
      - verif/jtagDebug_props.sv
      - verif/jtagDebugTb.sv
